// File: verilog.f
verilog/exec_pkg.sv
verilog/alu_if.sv
verilog/rotate_shift.sv
verilog/alu.sv
verilog/target_calc.sv
verilog/execute.sv
verilog/ex_stage_top.sv
sim/tb_ex_stage.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_ex_stage
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/ex_testdata.txt
// ctl0 {alu_op,alu_src,inv_a,inv_b} ctl1 {cin,sign,pass_a,pass_b} ctl2 {mem_write,0,instr_op}
// rd1 rd2 imm pc jump_in | exp alu_result branch_result jump_out flags {zero,ltz,err,0}
// ALU add, subtract, overflow, logic and shifts (A is rd2, B is rd1)
4000 0100 0008 0005 0003 0000 0000 0000 0008 0000 0000 0000
4000 1100 0008 1111 1234 0000 0000 0000 2346 0000 0000 0000
4001 1100 0008 0005 0005 0000 0000 0000 0000 0000 0000 1000
4001 1100 0008 0005 0003 0000 0000 0000 FFFE 0000 0000 0100
4000 0100 0008 0001 7FFF 0000 0000 0000 8000 0000 0000 0010
4000 0000 0008 0002 FFFF 0000 0000 0000 0001 0000 0000 0110
4000 0000 0008 0001 8000 0000 0000 0000 8001 0000 0000 0100
5000 0000 0008 FF00 F0F0 0000 0000 0000 F000 0000 0000 0100
6000 0000 0008 00F0 0F00 0000 0000 0000 0FF0 0000 0000 0000
7000 0000 0008 AAAA AAAA 0000 0000 0000 0000 0000 0000 1000
7010 0000 0008 0F0F 00FF 0000 0000 0000 F00F 0000 0000 0100
0000 0000 0008 0004 8001 0000 0000 0000 0018 0000 0000 0000
1000 0000 0008 0008 00F3 0000 0000 0000 F300 0000 0000 0100
3000 0000 0008 0004 F000 0000 0000 0000 0F00 0000 0000 0000
3000 0000 0008 0013 8000 0000 0000 0000 1000 0000 0000 0000
1000 0000 0008 000F 0003 0000 0000 0000 8000 0000 0000 0100
// Rotate right from a register and from the immediate (RORI)
2000 0000 0008 0004 1234 0000 0000 0000 4123 0000 0000 0000
2000 0000 0008 0000 1234 0000 0000 0000 1234 0000 0000 0000
2000 0000 0016 0000 00F1 0001 0000 0000 8078 0001 0000 0100
2000 0000 0016 0000 ABCD 0008 0000 0000 CDAB 0008 0000 0100
2000 0000 0016 0000 5A5A 0010 0000 0000 5A5A 0010 0000 0000
// Set group SEQ, SLT, SLE on A minus B, SCO on A plus B
4001 1100 001C 1234 1234 0000 0000 0000 0001 0000 0000 1000
4001 1100 001C 1235 1234 0000 0000 0000 0000 0000 0000 0100
4001 1100 001D 0005 0003 0000 0000 0000 0001 0000 0000 0100
4001 1100 001D 0001 8000 0000 0000 0000 0001 0000 0000 0110
4001 1100 001D FFFF 7FFF 0000 0000 0000 0000 0000 0000 0010
4001 1100 001E 8000 8000 0000 0000 0000 0001 0000 0000 1000
4001 1100 001E 0003 0005 0000 0000 0000 0000 0000 0000 0000
4001 1100 001E 0001 FFFE 0000 0000 0000 0001 0000 0000 0100
4000 0000 001F 0001 FFFF 0000 0000 0000 0001 0000 0000 1110
4000 0000 001F 0001 7FFF 0000 0000 0000 0000 0000 0000 0100
// BTR, SLBI, pass-through and store operands
4000 0000 0019 0000 1234 0000 0000 0000 2C48 0000 0000 0000
6100 0000 0012 0000 0012 0034 0000 0000 1234 0034 0000 0000
4100 0000 0012 0000 00AB 00CD 0000 0000 ABCD 00CD 0000 0100
4000 0010 0008 BEEF FFFF 0000 0000 0000 BEEF 0000 0000 0000
4100 0001 0008 0000 8000 8001 0000 0000 8001 8001 0000 0100
4000 0000 1008 1000 0020 0000 0000 0000 1020 0000 0000 0000
4100 0000 1008 2000 0000 0004 0000 0000 2004 0004 0000 0000
// Branch and jump targets
4000 0000 0008 0001 0001 0020 0100 0010 0002 0120 0110 0000
4000 0000 0008 0001 0001 0020 FFF0 0000 0002 0010 FFF0 0010
4000 0000 0005 0000 4000 0000 0200 0008 4000 0200 4008 0000
4000 0000 0007 0000 3000 0000 0100 FFFE 3000 0100 2FFE 0000
4000 0000 0008 0001 0001 0000 FFFC 0008 0002 FFFC 0004 0000

// File: sim/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

// Reads vectors from the data file, drives the stage, checks each result in order
module tb_ex_stage;

  localparam int words_per_vec = 12;   // Hex words per line of the data file
  localparam int max_vec       = 64;
  localparam int mem_words     = words_per_vec * max_vec;

  logic                        clk;
  logic                        arst_n;
  logic                        in_valid;
  logic [2:0]                  alu_op;
  logic                        alu_src;
  logic                        inv_a;
  logic                        inv_b;
  logic                        cin;
  logic                        sign;
  logic                        pass_a;
  logic                        pass_b;
  logic                        mem_write;
  logic [4:0]                  instr_op;
  logic [exec_pkg::data_w-1:0] read1data;
  logic [exec_pkg::data_w-1:0] read2data;
  logic [exec_pkg::data_w-1:0] immediate;
  logic [exec_pkg::data_w-1:0] pc;
  logic [exec_pkg::data_w-1:0] jump_in;
  logic                        out_valid;
  logic [exec_pkg::data_w-1:0] alu_result;
  logic [exec_pkg::data_w-1:0] branch_result;
  logic [exec_pkg::data_w-1:0] jump_out;
  logic                        zero;
  logic                        ltz;
  logic                        err;

  logic [15:0] vec_mem [0:mem_words-1];   // Flat copy of the data file
  int          vec_count;
  int          cycle;                     // Rising edges seen so far
  int          cycle_limit;
  int          seed;
  int          idx_q [$];                 // Vector index of each item in flight
  int          due_q [$];                 // Cycle its result must appear in

  ex_stage_top u_ex_stage_top (
    .clk           (clk),
    .arst_n        (arst_n),
    .in_valid      (in_valid),
    .alu_op        (alu_op),
    .alu_src       (alu_src),
    .inv_a         (inv_a),
    .inv_b         (inv_b),
    .cin           (cin),
    .sign          (sign),
    .pass_a        (pass_a),
    .pass_b        (pass_b),
    .mem_write     (mem_write),
    .instr_op      (instr_op),
    .read1data     (read1data),
    .read2data     (read2data),
    .immediate     (immediate),
    .pc            (pc),
    .jump_in       (jump_in),
    .out_valid     (out_valid),
    .alu_result    (alu_result),
    .branch_result (branch_result),
    .jump_out      (jump_out),
    .zero          (zero),
    .ltz           (ltz),
    .err           (err)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                // 40 ns period
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "%s", why);
  endtask

  // Control words hold one flag per nibble, see the data file header
  task automatic drive_vector(input int k);
    int b;
    b         = k * words_per_vec;
    alu_op    = vec_mem[b][14:12];
    alu_src   = vec_mem[b][8];
    inv_a     = vec_mem[b][4];
    inv_b     = vec_mem[b][0];
    cin       = vec_mem[b+1][12];
    sign      = vec_mem[b+1][8];
    pass_a    = vec_mem[b+1][4];
    pass_b    = vec_mem[b+1][0];
    mem_write = vec_mem[b+2][12];
    instr_op  = vec_mem[b+2][4:0];
    read1data = vec_mem[b+3];
    read2data = vec_mem[b+4];
    immediate = vec_mem[b+5];
    pc        = vec_mem[b+6];
    jump_in   = vec_mem[b+7];
    in_valid  = 1'b1;
    idx_q.push_back(k);
    due_q.push_back(cycle + 2);            // Sampled at the next edge, out one edge later
  endtask

  task automatic compare_result();
    int    k;
    int    due;
    int    b;
    string tag;
    k   = idx_q.pop_front();
    due = due_q.pop_front();
    b   = k * words_per_vec;
    tag = $sformatf("vector %0d", k);
    check({tag, " latency"}, due, cycle);
    check({tag, " alu_result"}, vec_mem[b+8], alu_result);
    check({tag, " branch_result"}, vec_mem[b+9], branch_result);
    check({tag, " jump_out"}, vec_mem[b+10], jump_out);
    check({tag, " zero"}, vec_mem[b+11][12], zero);
    check({tag, " ltz"}, vec_mem[b+11][8], ltz);
    check({tag, " err"}, vec_mem[b+11][4], err);
  endtask

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > cycle_limit) begin
      fail_run($sformatf("Timeout after %0d cycles with results still missing", cycle_limit));
    end
  end

  // Registered outputs are steady at the falling edge
  always @(negedge clk) begin
    if (arst_n && out_valid) begin
      if (idx_q.size() == 0) fail_run("out_valid went high with no item in flight");
      else compare_result();
    end
  end

  initial begin
    int   n;
    int   k;
    logic last_gap;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    alu_op    = '0;
    alu_src   = 1'b0;
    inv_a     = 1'b0;
    inv_b     = 1'b0;
    cin       = 1'b0;
    sign      = 1'b0;
    pass_a    = 1'b0;
    pass_b    = 1'b0;
    mem_write = 1'b0;
    instr_op  = '0;
    read1data = '0;
    read2data = '0;
    immediate = '0;
    pc        = '0;
    jump_in   = '0;
    seed      = 32'h1769916f;
    cycle     = 0;

    // Top nibble F never appears as an alu_op nibble, so it marks unused slots
    for (n = 0; n < mem_words; n++) vec_mem[n] = {4'hF, n[11:0]};
    $readmemh("sim/ex_testdata.txt", vec_mem);
    vec_count = 0;
    while (vec_count < max_vec && vec_mem[vec_count*words_per_vec][15:12] < 4'h8) begin
      vec_count++;
    end
    cycle_limit = 2 * vec_count + 20;      // At most one gap per vector, plus reset and drain
    if (vec_count == 0) fail_run("No vectors found in sim/ex_testdata.txt");

    repeat (2) @(posedge clk);
    #2 arst_n = 1'b1;
    @(negedge clk);
    check("out_valid after reset", 32'd0, {31'd0, out_valid});

    last_gap = 1'b1;                       // First vector goes straight in
    k = 0;
    while (k < vec_count) begin
      @(posedge clk);
      #2;
      if (!last_gap && ($random(seed) & 1)) begin
        in_valid = 1'b0;                   // Idle cycle between two vectors
        last_gap = 1'b1;
      end else begin
        drive_vector(k);
        k++;
        last_gap = 1'b0;
      end
    end
    @(posedge clk);
    #2 in_valid = 1'b0;

    repeat (4) @(posedge clk);             // Last result, then room for a stray extra one

    if (idx_q.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("%0d results never came out of the stage", idx_q.size());
      $display("Result: FAILED");
      $fatal(1, "results missing at the end of the run");
    end
  end

endmodule

`default_nettype wire

// File: verilog/ex_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

// Registered execute stage: input register, execute, output register
module ex_stage_top (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        in_valid,    // One-cycle strobe per item
  input  logic [2:0]                  alu_op,
  input  logic                        alu_src,
  input  logic                        inv_a,
  input  logic                        inv_b,
  input  logic                        cin,
  input  logic                        sign,
  input  logic                        pass_a,
  input  logic                        pass_b,
  input  logic                        mem_write,
  input  logic [4:0]                  instr_op,
  input  logic [exec_pkg::data_w-1:0] read1data,
  input  logic [exec_pkg::data_w-1:0] read2data,
  input  logic [exec_pkg::data_w-1:0] immediate,
  input  logic [exec_pkg::data_w-1:0] pc,
  input  logic [exec_pkg::data_w-1:0] jump_in,
  output logic                        out_valid,
  output logic [exec_pkg::data_w-1:0] alu_result,
  output logic [exec_pkg::data_w-1:0] branch_result,
  output logic [exec_pkg::data_w-1:0] jump_out,
  output logic                        zero,
  output logic                        ltz,
  output logic                        err
);

  // Input register
  logic                        valid_q;
  logic [2:0]                  alu_op_q;
  logic                        alu_src_q, inv_a_q, inv_b_q, cin_q, sign_q;
  logic                        pass_a_q, pass_b_q, mem_write_q;
  logic [4:0]                  instr_op_q;
  logic [exec_pkg::data_w-1:0] read1data_q, read2data_q, immediate_q, pc_q, jump_in_q;

  // Execute outputs, settle within the cycle
  logic [exec_pkg::data_w-1:0] ex_alu_result, ex_branch_result, ex_jump_out;
  logic                        ex_zero, ex_ltz, ex_err;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q     <= 1'b0;
      alu_op_q    <= '0;
      alu_src_q   <= 1'b0;
      inv_a_q     <= 1'b0;
      inv_b_q     <= 1'b0;
      cin_q       <= 1'b0;
      sign_q      <= 1'b0;
      pass_a_q    <= 1'b0;
      pass_b_q    <= 1'b0;
      mem_write_q <= 1'b0;
      instr_op_q  <= '0;
      read1data_q <= '0;
      read2data_q <= '0;
      immediate_q <= '0;
      pc_q        <= '0;
      jump_in_q   <= '0;
    end else begin
      valid_q <= in_valid;
      if (in_valid) begin                 // Hold the last item between strobes
        alu_op_q    <= alu_op;
        alu_src_q   <= alu_src;
        inv_a_q     <= inv_a;
        inv_b_q     <= inv_b;
        cin_q       <= cin;
        sign_q      <= sign;
        pass_a_q    <= pass_a;
        pass_b_q    <= pass_b;
        mem_write_q <= mem_write;
        instr_op_q  <= instr_op;
        read1data_q <= read1data;
        read2data_q <= read2data;
        immediate_q <= immediate;
        pc_q        <= pc;
        jump_in_q   <= jump_in;
      end
    end
  end

  execute u_execute (
    .alu_op        (alu_op_q),
    .alu_src       (alu_src_q),
    .inv_a         (inv_a_q),
    .inv_b         (inv_b_q),
    .cin           (cin_q),
    .sign          (sign_q),
    .pass_a        (pass_a_q),
    .pass_b        (pass_b_q),
    .mem_write     (mem_write_q),
    .instr_op      (instr_op_q),
    .read1data     (read1data_q),
    .read2data     (read2data_q),
    .immediate     (immediate_q),
    .pc            (pc_q),
    .jump_in       (jump_in_q),
    .alu_result    (ex_alu_result),
    .branch_result (ex_branch_result),
    .jump_out      (ex_jump_out),
    .zero          (ex_zero),
    .ltz           (ex_ltz),
    .err           (ex_err)
  );

  // Output register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid     <= 1'b0;
      alu_result    <= '0;
      branch_result <= '0;
      jump_out      <= '0;
      zero          <= 1'b0;
      ltz           <= 1'b0;
      err           <= 1'b0;
    end else begin
      out_valid <= valid_q;
      if (valid_q) begin                  // Results stay put while idle
        alu_result    <= ex_alu_result;
        branch_result <= ex_branch_result;
        jump_out      <= ex_jump_out;
        zero          <= ex_zero;
        ltz           <= ex_ltz;
        err           <= ex_err;
      end
    end
  end

  // Two-register valid chain, counted only once reset has been off long enough
  a_valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
    $past(arst_n, 2) |-> (out_valid == $past(in_valid, 2)))
    else $error("ex_stage_top: out_valid does not follow in_valid by two cycles");

endmodule

`default_nettype wire

// File: verilog/execute.sv
`timescale 1ns/1ps
`default_nettype none

// Execute stage datapath, purely combinational
module execute (
  input  logic [2:0]                  alu_op,
  input  logic                        alu_src,     // B from the immediate
  input  logic                        inv_a,
  input  logic                        inv_b,
  input  logic                        cin,
  input  logic                        sign,
  input  logic                        pass_a,      // Result is read1data
  input  logic                        pass_b,      // Result is the B operand
  input  logic                        mem_write,   // Store, A/B swap roles
  input  logic [4:0]                  instr_op,
  input  logic [exec_pkg::data_w-1:0] read1data,
  input  logic [exec_pkg::data_w-1:0] read2data,
  input  logic [exec_pkg::data_w-1:0] immediate,
  input  logic [exec_pkg::data_w-1:0] pc,
  input  logic [exec_pkg::data_w-1:0] jump_in,
  output logic [exec_pkg::data_w-1:0] alu_result,
  output logic [exec_pkg::data_w-1:0] branch_result,
  output logic [exec_pkg::data_w-1:0] jump_out,
  output logic                        zero,
  output logic                        ltz,
  output logic                        err
);

  alu_if alu_bus ();

  logic                        is_rori;
  logic                        is_btr;
  logic                        is_slbi;
  logic                        is_reg_jump;
  logic                        is_set;
  logic                        is_ror;       // ROR and RORI both carry op_ror
  logic                        set_hit;
  logic                        branch_ofl;
  logic [exec_pkg::data_w-1:0] rot_val;      // Register or immediate amount
  logic [exec_pkg::data_w-1:0] rot_amt;
  logic [exec_pkg::data_w-1:0] a_op;
  logic [exec_pkg::data_w-1:0] b_op;
  logic [exec_pkg::data_w-1:0] btr_val;

  // Opcode decode
  assign is_rori     = (instr_op == exec_pkg::opc_rori);
  assign is_btr      = (instr_op == exec_pkg::opc_btr);
  assign is_slbi     = (instr_op == exec_pkg::opc_slbi);
  assign is_reg_jump = (instr_op == exec_pkg::opc_jr) || (instr_op == exec_pkg::opc_jalr);
  assign is_set      = (instr_op[4:2] == exec_pkg::set_marker);
  assign is_ror      = (alu_op == exec_pkg::op_ror);

  // Operand A
  always_comb begin
    if (is_slbi)        a_op = read2data << 8;   // Byte moves up, imm fills low byte
    else if (mem_write) a_op = read1data;        // Store address base
    else                a_op = read2data;
  end

  // Rotate right by n is rotate left by -n, only the low bits matter
  assign rot_val = is_rori ? immediate : read1data;
  assign rot_amt = is_ror ? -rot_val : rot_val;

  // Operand B
  always_comb begin
    if (alu_src)        b_op = immediate;
    else if (mem_write) b_op = read2data;
    else                b_op = rot_amt;
  end

  assign alu_bus.a     = a_op;
  assign alu_bus.b     = b_op;
  assign alu_bus.cin   = cin;
  assign alu_bus.op    = is_ror ? exec_pkg::op_rol : alu_op;
  assign alu_bus.inv_a = inv_a;
  assign alu_bus.inv_b = inv_b;
  assign alu_bus.sign  = sign;

  alu u_alu (
    .bus (alu_bus.alu)
  );

  target_calc u_target_calc (
    .pc            (pc),
    .immediate     (immediate),
    .jump_in       (jump_in),
    .read2data     (read2data),
    .is_reg_jump   (is_reg_jump),
    .branch_result (branch_result),
    .jump_out      (jump_out),
    .branch_ofl    (branch_ofl)
  );

  // Mirror read2data end for end
  always_comb begin
    for (int i = 0; i < exec_pkg::data_w; i++) begin
      btr_val[i] = read2data[exec_pkg::data_w-1-i];
    end
  end

  // Set condition from the ALU flags of A - B (or A + B for SCO)
  always_comb begin
    case (instr_op[1:0])
      exec_pkg::cond_seq: set_hit = alu_bus.zero;
      exec_pkg::cond_slt: set_hit = alu_bus.ltz;
      exec_pkg::cond_sle: set_hit = alu_bus.zero | alu_bus.ltz;
      exec_pkg::cond_sco: set_hit = alu_bus.ofl;
      default:            set_hit = 1'b0;
    endcase
  end

  // Result mux, earlier choices win
  always_comb begin
    if (is_btr)      alu_result = btr_val;
    else if (is_set) alu_result = {{(exec_pkg::data_w-1){1'b0}}, set_hit};
    else if (pass_b) alu_result = b_op;
    else if (pass_a) alu_result = read1data;
    else             alu_result = alu_bus.result;
  end

  assign zero = alu_bus.zero;
  assign ltz  = alu_bus.ltz;

  // Pass-through instructions never raise an error
  assign err = (alu_bus.ofl | branch_ofl) & ~(pass_a | pass_b);

  // Decode must never ask for both pass-throughs, the mux would hide pass_a
  always_comb begin
    a_single_pass: assert final (!(pass_a && pass_b))
      else $error("execute: pass_a and pass_b both high");
  end

endmodule

`default_nettype wire

// File: verilog/target_calc.sv
`timescale 1ns/1ps
`default_nettype none

// Branch and jump target adders
module target_calc (
  input  logic [exec_pkg::data_w-1:0] pc,
  input  logic [exec_pkg::data_w-1:0] immediate,      // Branch displacement
  input  logic [exec_pkg::data_w-1:0] jump_in,        // Jump offset
  input  logic [exec_pkg::data_w-1:0] read2data,      // Base for JR/JALR
  input  logic                        is_reg_jump,
  output logic [exec_pkg::data_w-1:0] branch_result,
  output logic [exec_pkg::data_w-1:0] jump_out,
  output logic                        branch_ofl
);

  logic [exec_pkg::data_w:0]   branch_sum;   // Carry kept for the error flag
  logic [exec_pkg::data_w-1:0] jump_base;

  assign branch_sum    = {1'b0, pc} + {1'b0, immediate};
  assign branch_result = branch_sum[exec_pkg::data_w-1:0];
  assign branch_ofl    = branch_sum[exec_pkg::data_w];  // Unsigned carry-out

  // Register jumps are based on the register, all others on pc
  assign jump_base = is_reg_jump ? read2data : pc;
  assign jump_out  = jump_base + jump_in;               // Wraps silently

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

// Main ALU: adder, logic ops and the barrel shifter behind one result mux
module alu (
  alu_if.alu bus
);

  logic [exec_pkg::data_w-1:0] a_in;        // A after optional inversion
  logic [exec_pkg::data_w-1:0] b_in;        // B after optional inversion
  logic [exec_pkg::data_w-1:0] rs_out;      // Rotate/shift result
  logic [exec_pkg::data_w:0]   sum;         // Extra bit is carry-out
  logic                        signed_ofl;

  assign a_in = bus.inv_a ? ~bus.a : bus.a;
  assign b_in = bus.inv_b ? ~bus.b : bus.b;   // inv_b with cin gives A - B

  assign sum = {1'b0, a_in} + {1'b0, b_in} + {{exec_pkg::data_w{1'b0}}, bus.cin};

  // Operands of like sign giving a result of the other sign
  assign signed_ofl = (a_in[exec_pkg::data_w-1] == b_in[exec_pkg::data_w-1]) &&
                      (sum[exec_pkg::data_w-1] != a_in[exec_pkg::data_w-1]);

  rotate_shift u_rotate_shift (
    .data    (a_in),
    .amount  (b_in[exec_pkg::shamt_w-1:0]),  // Only low bits count
    .mode    (bus.op[1:0]),
    .shifted (rs_out)
  );

  always_comb begin
    bus.ofl = 1'b0;
    case (bus.op)
      exec_pkg::op_add: begin
        bus.result = sum[exec_pkg::data_w-1:0];
        bus.ofl    = bus.sign ? signed_ofl : sum[exec_pkg::data_w];  // Unsigned uses carry
      end
      exec_pkg::op_and: bus.result = a_in & b_in;
      exec_pkg::op_or:  bus.result = a_in | b_in;
      exec_pkg::op_xor: bus.result = a_in ^ b_in;
      default:          bus.result = rs_out;       // rol, sll, srl
    endcase
  end

  // Flags follow the ALU result, not the final muxed stage result
  assign bus.zero = (bus.result == '0);
  assign bus.ltz  = bus.result[exec_pkg::data_w-1] ^ bus.ofl;  // Corrected for overflow

  // Signed A - B must agree with a direct signed compare of the operands
  always_comb begin
    if (bus.op == exec_pkg::op_add && bus.sign && bus.inv_b && bus.cin &&
        !bus.inv_a) begin
      a_ltz_signed: assert final (bus.ltz == ($signed(bus.a) < $signed(bus.b)))
        else $error("alu: ltz disagrees with signed compare of %h and %h", bus.a, bus.b);
    end
  end

endmodule

`default_nettype wire

// File: verilog/rotate_shift.sv
`timescale 1ns/1ps
`default_nettype none

// Log-depth barrel shifter, one level per amount bit
module rotate_shift (
  input  logic [exec_pkg::data_w-1:0]  data,
  input  logic [exec_pkg::shamt_w-1:0] amount,
  input  logic [1:0]                   mode,     // op[1:0]: x0 rotl, 01 sll, 11 srl
  output logic [exec_pkg::data_w-1:0]  shifted
);

  logic [exec_pkg::data_w-1:0] stage [0:exec_pkg::shamt_w];  // stage[k] after k levels
  logic                        rotate;   // Wrap bits instead of zero fill
  logic                        right;    // Only srl moves right

  assign rotate   = ~mode[0];
  assign right    = mode[1] & mode[0];
  assign stage[0] = data;

  for (genvar i = 0; i < exec_pkg::shamt_w; i++) begin : g_level
    logic [(1<<i)-1:0]           fill;      // Bits entering from the right
    logic [exec_pkg::data_w-1:0] left_v;
    logic [exec_pkg::data_w-1:0] right_v;

    // Top bits wrap around on a rotate
    assign fill    = rotate ? stage[i][exec_pkg::data_w-1 -: (1<<i)] : '0;
    assign left_v  = {stage[i][exec_pkg::data_w-1-(1<<i):0], fill};
    assign right_v = {{(1<<i){1'b0}}, stage[i][exec_pkg::data_w-1:(1<<i)]};  // Logical

    // Level passes its input through when this amount bit is clear
    assign stage[i+1] = !amount[i] ? stage[i] :
                        right      ? right_v  : left_v;
  end

  assign shifted = stage[exec_pkg::shamt_w];

endmodule

`default_nettype wire

// File: verilog/alu_if.sv
`timescale 1ns/1ps
`default_nettype none

// Combinational link between the operand logic in execute and the ALU
interface alu_if ();

  logic [exec_pkg::data_w-1:0] a;       // Operand A before inversion
  logic [exec_pkg::data_w-1:0] b;       // Operand B, low bits also the shift amount
  logic                        cin;     // Carry into the adder
  logic [2:0]                  op;      // Never op_ror here
  logic                        inv_a;
  logic                        inv_b;
  logic                        sign;    // Signed overflow select

  logic [exec_pkg::data_w-1:0] result;
  logic                        ofl;     // Only meaningful for op_add
  logic                        zero;
  logic                        ltz;     // True signed less-than

  modport drv (
    output a, b, cin, op, inv_a, inv_b, sign,
    input  result, ofl, zero, ltz
  );

  modport alu (
    input  a, b, cin, op, inv_a, inv_b, sign,
    output result, ofl, zero, ltz
  );

endinterface

`default_nettype wire

// File: verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

  // Data path
  localparam int data_w  = 16;               // Word width of the whole stage
  localparam int shamt_w = $clog2(data_w);   // Rotate/shift amount bits

  // ALU operation codes, driven on alu_op by decode
  localparam logic [2:0] op_rol = 3'b000;    // Rotate left
  localparam logic [2:0] op_sll = 3'b001;    // Shift left logical
  localparam logic [2:0] op_ror = 3'b010;    // Rotate right, rewritten to rol
  localparam logic [2:0] op_srl = 3'b011;    // Shift right logical
  localparam logic [2:0] op_add = 3'b100;    // Add with carry-in
  localparam logic [2:0] op_and = 3'b101;
  localparam logic [2:0] op_or  = 3'b110;
  localparam logic [2:0] op_xor = 3'b111;

  // Instruction opcodes that need special handling in execute
  localparam logic [4:0] opc_rori = 5'b10110;  // Rotate right by immediate
  localparam logic [4:0] opc_btr  = 5'b11001;  // Bit reverse
  localparam logic [4:0] opc_slbi = 5'b10010;  // Shift left byte, then or/add imm
  localparam logic [4:0] opc_jr   = 5'b00101;  // Jump register
  localparam logic [4:0] opc_jalr = 5'b00111;  // Jump and link register

  // Set group is 111xx, low two bits pick the condition
  localparam logic [2:0] set_marker = 3'b111;
  localparam logic [1:0] cond_seq   = 2'b00;   // A == B
  localparam logic [1:0] cond_slt   = 2'b01;   // A <  B, signed
  localparam logic [1:0] cond_sle   = 2'b10;   // A <= B, signed
  localparam logic [1:0] cond_sco   = 2'b11;   // Carry/overflow of the add

endpackage

`default_nettype wire
